//--- safety_cl_periph.f
safety_cl_periph_pkg.sv
err_fifo.sv
cl_reg_demux.sv
bus_err_unit.sv
cl_intc.sv
safety_cl_periph.sv
tb_clk_gen.sv
tb_safety_cl_periph.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the safety_cl_periph testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_safety_cl_periph

verilator --binary --timing -Wno-fatal --top-module "$TOP" \
  -f safety_cl_periph.f -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
  echo "Test passed"
  exit 0
else
  echo "Pass line missing from $LOG"
  exit 1
fi

//--- tb_safety_cl_periph.sv
/*
  Testbench top: DUT instance, register bus and monitored bus drivers,
  compare tasks and directed tests of the core-local peripheral block
*/
`timescale 1ns/1ps

module tb_safety_cl_periph;

  localparam int unsigned RspTimeout   = 4;
  localparam int unsigned IrqTimeout   = 20;
  localparam int unsigned ResetTimeout = 10;

  logic                                          clk;
  logic                                          reset;
  safety_cl_periph_pkg::reg_req_t                reg_req;
  safety_cl_periph_pkg::reg_rsp_t                reg_rsp;
  // Instruction, data, shadow
  safety_cl_periph_pkg::obi_mon_t                mon [3];
  logic [safety_cl_periph_pkg::NumExtIrqs-1:0]   irqs;
  logic [safety_cl_periph_pkg::NumTimerIrqs-1:0] timer_irqs;
  logic                                          irq_valid;
  safety_cl_periph_pkg::irq_id_t                 irq_id;
  logic                                          irq_ready;

  tb_clk_gen i_clk_gen (
    .clk_o   ( clk   ),
    .reset_o ( reset )
  );

  safety_cl_periph safety_cl_periph_inst (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .reg_req_i    ( reg_req    ),
    .reg_rsp_o    ( reg_rsp    ),
    .instr_mon_i  ( mon[0]     ),
    .data_mon_i   ( mon[1]     ),
    .shadow_mon_i ( mon[2]     ),
    .irqs_i       ( irqs       ),
    .timer_irqs_i ( timer_irqs ),
    .irq_valid_o  ( irq_valid  ),
    .irq_id_o     ( irq_id     ),
    .irq_ready_i  ( irq_ready  )
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rsp(input string name, input safety_cl_periph_pkg::reg_rsp_t exp,
                           input safety_cl_periph_pkg::reg_rsp_t act);
    if (act !== exp) begin
      stop_on_error($sformatf(
        "CHECK FAILED %s: expected valid=%b error=%b rdata=%h, actual valid=%b error=%b rdata=%h",
        name, exp.valid, exp.error, exp.rdata, act.valid, act.error, act.rdata));
    end
  endtask

  task automatic check_irq(input string name, input safety_cl_periph_pkg::irq_id_t exp,
                           input safety_cl_periph_pkg::irq_id_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s: expected id %0d, actual id %0d",
                              name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  function automatic safety_cl_periph_pkg::reg_rsp_t rsp_word(input logic err,
                                                             input logic [31:0] rdata);
    safety_cl_periph_pkg::reg_rsp_t rsp;
    rsp.valid = 1'b1;
    rsp.error = err;
    rsp.rdata = rdata;
    return rsp;
  endfunction

  function automatic logic [31:0] status_word(input logic ovf, input int unsigned count);
    return {ovf, 31'(count)};
  endfunction

  function automatic logic [31:0] intc_reg(
    input logic [safety_cl_periph_pkg::RegOffsetWidth-1:0] off);
    return safety_cl_periph_pkg::PeriphBaseAddr + safety_cl_periph_pkg::IntcOffset + 32'(off);
  endfunction

  // Bus index 0 instruction, 1 data, 2 shadow
  function automatic logic [31:0] err_reg(input int unsigned bus,
    input logic [safety_cl_periph_pkg::RegOffsetWidth-1:0] off);
    logic [31:0] win;
    case (bus)
      0:       win = safety_cl_periph_pkg::InstrErrOffset;
      1:       win = safety_cl_periph_pkg::DataErrOffset;
      default: win = safety_cl_periph_pkg::ShadowErrOffset;
    endcase
    return safety_cl_periph_pkg::PeriphBaseAddr + win + 32'(off);
  endfunction

  function automatic logic is_mapped(input logic [31:0] addr);
    logic [31:0] win [4];
    logic [31:0] base;
    win = '{safety_cl_periph_pkg::IntcOffset, safety_cl_periph_pkg::InstrErrOffset,
            safety_cl_periph_pkg::DataErrOffset, safety_cl_periph_pkg::ShadowErrOffset};
    is_mapped = 1'b0;
    foreach (win[i]) begin
      base = safety_cl_periph_pkg::PeriphBaseAddr + win[i];
      if (addr >= base && addr < base + safety_cl_periph_pkg::PeriphWindow) begin
        is_mapped = 1'b1;
      end
    end
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // One-cycle strobe, response expected in the following cycle
  task automatic reg_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata,
                            output safety_cl_periph_pkg::reg_rsp_t rsp);
    int unsigned cycles;
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    cycles = 0;
    do begin
      next_cycle();
      reg_req.valid = 1'b0;
      cycles++;
    end while (!reg_rsp.valid && cycles < RspTimeout);
    if (!reg_rsp.valid || cycles != 1) begin
      stop_on_error($sformatf("No register response one cycle after the request to %h", addr));
    end
    rsp = reg_rsp;
  endtask

  task automatic reg_read(input string name, input logic [31:0] addr, input logic [31:0] exp);
    safety_cl_periph_pkg::reg_rsp_t rsp;
    reg_access(1'b0, addr, '0, rsp);
    check_rsp(name, rsp_word(1'b0, exp), rsp);
  endtask

  task automatic reg_write(input string name, input logic [31:0] addr, input logic [31:0] wdata);
    safety_cl_periph_pkg::reg_rsp_t rsp;
    reg_access(1'b1, addr, wdata, rsp);
    check_rsp(name, rsp_word(1'b0, '0), rsp);
  endtask

  task automatic bus_accept(input int unsigned bus, input logic [31:0] addr);
    mon[bus].req  = 1'b1;
    mon[bus].gnt  = 1'b1;
    mon[bus].addr = addr;
    next_cycle();
    mon[bus] = '0;
  endtask

  task automatic bus_respond(input int unsigned bus, input logic [1:0] err);
    mon[bus].rvalid = 1'b1;
    mon[bus].err    = err;
    next_cycle();
    mon[bus] = '0;
  endtask

  task automatic wait_irq_valid(input string name);
    int unsigned cycles;
    cycles = 0;
    while (!irq_valid && cycles < IrqTimeout) begin
      next_cycle();
      cycles++;
    end
    if (!irq_valid) begin
      stop_on_error($sformatf("%s: irq_valid_o did not rise within %0d cycles",
                              name, IrqTimeout));
    end
  endtask

  task automatic test_reset_state();
    check_bit("reset_state irq_valid", 1'b0, irq_valid);
    check_bit("reset_state rsp valid", 1'b0, reg_rsp.valid);
    check_bit("reset_state bus error irqs", 1'b0, |safety_cl_periph_inst.bus_err_irq);
    reg_read("reset_state enable", intc_reg(safety_cl_periph_pkg::RegIntcEnable), '0);
    reg_read("reset_state pending", intc_reg(safety_cl_periph_pkg::RegIntcPending), '0);
    for (int unsigned b = 0; b < 3; b++) begin
      reg_read($sformatf("reset_state status %0d", b),
               err_reg(b, safety_cl_periph_pkg::RegErrStatus), status_word(1'b0, 0));
    end
  endtask

  task automatic test_unmapped();
    logic [31:0]                    addr;
    logic [31:0]                    mask;
    safety_cl_periph_pkg::reg_rsp_t rsp;
    // Gap between the controller window and the error units
    addr = safety_cl_periph_pkg::PeriphBaseAddr + 32'h800;
    reg_access(1'b0, addr, '0, rsp);
    check_rsp("unmapped gap", rsp_word(1'b1, safety_cl_periph_pkg::ErrRespVal), rsp);
    do begin
      addr = $urandom();
    end while (is_mapped(addr));
    reg_access(1'b0, addr, '0, rsp);
    check_rsp("unmapped random", rsp_word(1'b1, safety_cl_periph_pkg::ErrRespVal), rsp);
    mask = $urandom() & ((32'h1 << safety_cl_periph_pkg::NumIntrSrc) - 32'h1);
    reg_write("unmapped enable write", intc_reg(safety_cl_periph_pkg::RegIntcEnable), mask);
    reg_read("unmapped enable readback", intc_reg(safety_cl_periph_pkg::RegIntcEnable), mask);
  endtask

  task automatic test_error_record();
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [1:0]  code;
    addr_a = $urandom() & ~32'h3;
    addr_b = $urandom() & ~32'h3;
    code   = 2'($urandom_range(3, 1));
    bus_accept(1, addr_a);
    bus_accept(1, addr_b);
    bus_respond(1, 2'b00);
    bus_respond(1, code);
    reg_read("error_record status", err_reg(1, safety_cl_periph_pkg::RegErrStatus),
             status_word(1'b0, 1));
    reg_read("error_record address", err_reg(1, safety_cl_periph_pkg::RegErrAddr), addr_b);
    reg_read("error_record code", err_reg(1, safety_cl_periph_pkg::RegErrCode), 32'(code));
    reg_read("error_record pending", intc_reg(safety_cl_periph_pkg::RegIntcPending),
             32'h1 << 11);
    reg_write("error_record pop", err_reg(1, safety_cl_periph_pkg::RegErrPop), $urandom());
    reg_read("error_record status after pop", err_reg(1, safety_cl_periph_pkg::RegErrStatus),
             status_word(1'b0, 0));
  endtask

  task automatic test_overflow();
    logic [31:0] addr;
    logic [31:0] first_addr;
    logic [1:0]  code;
    logic [1:0]  first_code;
    for (int k = 0; k <= safety_cl_periph_pkg::NumStoredErrors; k++) begin
      addr = $urandom() & ~32'h3;
      code = 2'($urandom_range(3, 1));
      if (k == 0) begin
        first_addr = addr;
        first_code = code;
      end
      bus_accept(2, addr);
      bus_respond(2, code);
    end
    reg_read("overflow status", err_reg(2, safety_cl_periph_pkg::RegErrStatus),
             status_word(1'b1, safety_cl_periph_pkg::NumStoredErrors));
    reg_read("overflow head address", err_reg(2, safety_cl_periph_pkg::RegErrAddr), first_addr);
    reg_read("overflow head code", err_reg(2, safety_cl_periph_pkg::RegErrCode),
             32'(first_code));
    // Drain the store and clear the sticky flag
    reg_write("overflow clear", err_reg(2, safety_cl_periph_pkg::RegErrStatus), '0);
    for (int k = 0; k < safety_cl_periph_pkg::NumStoredErrors; k++) begin
      reg_write("overflow pop", err_reg(2, safety_cl_periph_pkg::RegErrPop), '0);
    end
    reg_read("overflow drained", err_reg(2, safety_cl_periph_pkg::RegErrStatus),
             status_word(1'b0, 0));
  endtask

  task automatic test_priority();
    reg_write("priority enable", intc_reg(safety_cl_periph_pkg::RegIntcEnable),
              (32'h1 << 3) | (32'h1 << 10));
    reg_write("priority clear pending", intc_reg(safety_cl_periph_pkg::RegIntcPending),
              (32'h1 << safety_cl_periph_pkg::NumIntrSrc) - 32'h1);
    // Source 10 from an instruction bus error, 5 stays disabled
    bus_accept(0, $urandom() & ~32'h3);
    bus_respond(0, 2'b01);
    irqs[3] = 1'b1;
    irqs[5] = 1'b1;
    next_cycle();
    next_cycle();
    wait_irq_valid("priority first");
    check_irq("priority first id", 4'd10, irq_id);
    reg_write("priority pop", err_reg(0, safety_cl_periph_pkg::RegErrPop), '0);
    // Line 10 is low now, its pending bit keeps it presented
    next_cycle();
    next_cycle();
    check_bit("priority held valid", 1'b1, irq_valid);
    check_irq("priority held id", 4'd10, irq_id);
    irq_ready = 1'b1;
    next_cycle();
    irq_ready = 1'b0;
    check_bit("priority valid after ack", 1'b0, irq_valid);
    wait_irq_valid("priority second");
    check_irq("priority second id", 4'd3, irq_id);
    irqs[3]   = 1'b0;
    irq_ready = 1'b1;
    next_cycle();
    irq_ready = 1'b0;
    for (int k = 0; k < IrqTimeout; k++) begin
      check_bit("priority disabled source", 1'b0, irq_valid);
      next_cycle();
    end
    irqs = '0;
  endtask

  initial begin
    int unsigned cycles;
    reg_req    = '0;
    mon[0]     = '0;
    mon[1]     = '0;
    mon[2]     = '0;
    irqs       = '0;
    timer_irqs = '0;
    irq_ready  = 1'b0;
    void'($urandom(32'h8a1f_b59c));
    cycles = 0;
    // Reset changes just after an edge, so sample it on the edge
    do begin
      @(posedge clk);
      cycles++;
    end while (reset && cycles < ResetTimeout);
    if (reset) begin
      stop_on_error("Reset was never released");
    end
    #1;
    test_reset_state();
    test_unmapped();
    test_error_record();
    test_overflow();
    test_priority();
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
/*
  Testbench clock and reset: 10 ns clock, reset high for two cycles
*/
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

//--- safety_cl_periph.sv
/*
  Core-local peripheral subsystem: register demux, three bus error units
  and the interrupt controller
*/
`timescale 1ns/1ps

module safety_cl_periph (
  input  logic                                          clk_i,
  input  logic                                          reset_i,

  input  safety_cl_periph_pkg::reg_req_t                reg_req_i,
  output safety_cl_periph_pkg::reg_rsp_t                reg_rsp_o,

  input  safety_cl_periph_pkg::obi_mon_t                instr_mon_i,
  input  safety_cl_periph_pkg::obi_mon_t                data_mon_i,
  input  safety_cl_periph_pkg::obi_mon_t                shadow_mon_i,

  input  logic [safety_cl_periph_pkg::NumExtIrqs-1:0]   irqs_i,
  input  logic [safety_cl_periph_pkg::NumTimerIrqs-1:0] timer_irqs_i,

  output logic                                          irq_valid_o,
  output safety_cl_periph_pkg::irq_id_t                 irq_id_o,
  input  logic                                          irq_ready_i
);

  safety_cl_periph_pkg::reg_req_t [safety_cl_periph_pkg::NumPeriphs-1:0] periph_req;
  safety_cl_periph_pkg::reg_rsp_t [safety_cl_periph_pkg::NumPeriphs-1:0] periph_rsp;

  // Instruction, data, shadow
  safety_cl_periph_pkg::obi_mon_t [2:0]        bus_mon;
  logic [2:0]                                  bus_err_irq;
  logic [safety_cl_periph_pkg::NumIntrSrc-1:0] intr_src;

  cl_reg_demux i_reg_demux (
    .clk_i,
    .reset_i,
    .in_req_i  ( reg_req_i  ),
    .in_rsp_o  ( reg_rsp_o  ),
    .out_req_o ( periph_req ),
    .out_rsp_i ( periph_rsp )
  );

  assign bus_mon = {shadow_mon_i, data_mon_i, instr_mon_i};

  for (genvar g = 0; g < 3; g++) begin : gen_bus_err
    localparam int unsigned Idx = int'(safety_cl_periph_pkg::IdxInstrErr) + g;

    bus_err_unit i_bus_err_unit (
      .clk_i,
      .reset_i,
      .mon_i     ( bus_mon[g]      ),
      .reg_req_i ( periph_req[Idx] ),
      .reg_rsp_o ( periph_rsp[Idx] ),
      .err_irq_o ( bus_err_irq[g]  )
    );
  end

  // Sources 0-7 external, 8-9 timer, 10-12 bus errors
  assign intr_src = {bus_err_irq, timer_irqs_i, irqs_i};

  cl_intc i_intc (
    .clk_i,
    .reset_i,
    .intr_src_i  ( intr_src                                   ),
    .reg_req_i   ( periph_req[safety_cl_periph_pkg::IdxIntc] ),
    .reg_rsp_o   ( periph_rsp[safety_cl_periph_pkg::IdxIntc] ),
    .irq_valid_o,
    .irq_id_o,
    .irq_ready_i
  );

endmodule

//--- cl_intc.sv
/*
  Simplified interrupt controller: enable and pending registers,
  highest-numbered source wins, valid/ready notification to the core
*/
`timescale 1ns/1ps

module cl_intc (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic [safety_cl_periph_pkg::NumIntrSrc-1:0] intr_src_i,
  input  safety_cl_periph_pkg::reg_req_t              reg_req_i,
  output safety_cl_periph_pkg::reg_rsp_t              reg_rsp_o,
  output logic                                        irq_valid_o,
  output safety_cl_periph_pkg::irq_id_t               irq_id_o,
  input  logic                                        irq_ready_i
);

  logic [safety_cl_periph_pkg::NumIntrSrc-1:0] enable_q;
  logic [safety_cl_periph_pkg::NumIntrSrc-1:0] pending_q;
  logic [safety_cl_periph_pkg::NumIntrSrc-1:0] clr_mask;
  logic [safety_cl_periph_pkg::NumIntrSrc-1:0] candidates;
  logic [safety_cl_periph_pkg::RegOffsetWidth-1:0] offset;
  logic                                        enable_wr;
  logic                                        pending_wr;
  logic                                        ack;
  logic                                        irq_valid_q;
  safety_cl_periph_pkg::irq_id_t               irq_id_d;
  safety_cl_periph_pkg::irq_id_t               irq_id_q;
  logic [safety_cl_periph_pkg::DataWidth-1:0]  rdata_d;
  safety_cl_periph_pkg::reg_rsp_t              rsp_q;

  assign offset     = reg_req_i.addr[safety_cl_periph_pkg::RegOffsetWidth-1:0];
  assign enable_wr  = reg_req_i.valid & reg_req_i.write &
                      (offset == safety_cl_periph_pkg::RegIntcEnable);
  assign pending_wr = reg_req_i.valid & reg_req_i.write &
                      (offset == safety_cl_periph_pkg::RegIntcPending);
  assign ack        = irq_valid_q & irq_ready_i;

  // Acknowledged id and write-one-to-clear bits
  always_comb begin
    clr_mask = '0;
    if (ack) begin
      clr_mask[irq_id_q] = 1'b1;
    end
    if (pending_wr) begin
      clr_mask = clr_mask | reg_req_i.wdata[safety_cl_periph_pkg::NumIntrSrc-1:0];
    end
  end

  assign candidates = pending_q & enable_q & ~clr_mask;

  always_comb begin
    irq_id_d = '0;
    for (int i = 0; i < safety_cl_periph_pkg::NumIntrSrc; i++) begin
      if (candidates[i]) begin
        irq_id_d = safety_cl_periph_pkg::irq_id_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q    <= '0;
      pending_q   <= '0;
      irq_valid_q <= 1'b0;
      irq_id_q    <= '0;
    end else begin
      if (enable_wr) begin
        enable_q <= reg_req_i.wdata[safety_cl_periph_pkg::NumIntrSrc-1:0];
      end
      pending_q   <= (pending_q | intr_src_i) & ~clr_mask;
      // One idle cycle after every acknowledge
      irq_valid_q <= (|candidates) & ~ack;
      irq_id_q    <= irq_id_d;
    end
  end

  assign irq_valid_o = irq_valid_q;
  assign irq_id_o    = irq_id_q;

  always_comb begin
    rdata_d = '0;
    if (!reg_req_i.write) begin
      case (offset)
        safety_cl_periph_pkg::RegIntcEnable:  rdata_d = 32'(enable_q);
        safety_cl_periph_pkg::RegIntcPending: rdata_d = 32'(pending_q);
        default:                              rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q.valid <= 1'b0;
    end else begin
      rsp_q.valid <= reg_req_i.valid;
    end
    rsp_q.error <= 1'b0;
    rsp_q.rdata <= rdata_d;
  end

  assign reg_rsp_o = rsp_q;

endmodule

//--- bus_err_unit.sv
/*
  Bus error unit: tracks outstanding addresses of one monitored bus,
  stores failed transactions and serves them through a register window
*/
`timescale 1ns/1ps

module bus_err_unit (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  safety_cl_periph_pkg::obi_mon_t mon_i,
  input  safety_cl_periph_pkg::reg_req_t reg_req_i,
  output safety_cl_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                           err_irq_o
);

  logic [safety_cl_periph_pkg::AddrWidth-1:0]   outst_addr;
  logic                                         outst_empty;
  safety_cl_periph_pkg::err_entry_t             new_err;
  safety_cl_periph_pkg::err_entry_t             head_err;
  logic                                         err_push;
  logic                                         err_pop;
  logic                                         err_empty;
  logic                                         err_full;
  logic [safety_cl_periph_pkg::ErrCntWidth-1:0] err_count;
  logic                                         overflow_q;
  logic [safety_cl_periph_pkg::RegOffsetWidth-1:0] offset;
  logic [safety_cl_periph_pkg::DataWidth-1:0]   rdata_d;
  safety_cl_periph_pkg::reg_rsp_t               rsp_q;

  err_fifo #(
    .Depth   ( safety_cl_periph_pkg::NumOutstanding       ),
    .entry_t ( logic [safety_cl_periph_pkg::AddrWidth-1:0] )
  ) i_outst_fifo (
    .clk_i,
    .reset_i,
    .push_i  ( mon_i.req & mon_i.gnt ),
    .data_i  ( mon_i.addr            ),
    .pop_i   ( mon_i.rvalid          ),
    .data_o  ( outst_addr            ),
    .empty_o ( outst_empty           ),
    .full_o  (                       ),
    .count_o (                       )
  );

  // Orphan responses are logged at address zero
  assign new_err.addr = outst_empty ? '0 : outst_addr;
  assign new_err.err  = mon_i.err;
  assign err_push     = mon_i.rvalid & (|mon_i.err);

  assign offset  = reg_req_i.addr[safety_cl_periph_pkg::RegOffsetWidth-1:0];
  assign err_pop = reg_req_i.valid & reg_req_i.write & (offset == safety_cl_periph_pkg::RegErrPop);

  err_fifo #(
    .Depth   ( safety_cl_periph_pkg::NumStoredErrors ),
    .entry_t ( safety_cl_periph_pkg::err_entry_t    )
  ) i_err_fifo (
    .clk_i,
    .reset_i,
    .push_i  ( err_push  ),
    .data_i  ( new_err   ),
    .pop_i   ( err_pop   ),
    .data_o  ( head_err  ),
    .empty_o ( err_empty ),
    .full_o  ( err_full  ),
    .count_o ( err_count )
  );

  assign err_irq_o = ~err_empty;

  // Sticky until software writes the status register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      overflow_q <= 1'b0;
    end else if (err_push && err_full) begin
      overflow_q <= 1'b1;
    end else if (reg_req_i.valid && reg_req_i.write &&
                 offset == safety_cl_periph_pkg::RegErrStatus) begin
      overflow_q <= 1'b0;
    end
  end

  always_comb begin
    rdata_d = '0;
    if (!reg_req_i.write) begin
      case (offset)
        safety_cl_periph_pkg::RegErrStatus: begin
          rdata_d[safety_cl_periph_pkg::DataWidth-1]     = overflow_q;
          rdata_d[safety_cl_periph_pkg::ErrCntWidth-1:0] = err_count;
        end
        safety_cl_periph_pkg::RegErrAddr: rdata_d = head_err.addr;
        safety_cl_periph_pkg::RegErrCode: begin
          rdata_d[safety_cl_periph_pkg::NumBusErrBits-1:0] = head_err.err;
        end
        default: rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q.valid <= 1'b0;
    end else begin
      rsp_q.valid <= reg_req_i.valid;
    end
    rsp_q.error <= 1'b0;
    rsp_q.rdata <= rdata_d;
  end

  assign reg_rsp_o = rsp_q;

endmodule

//--- cl_reg_demux.sv
/*
  Register bus demultiplexer: address decode over the peripheral windows,
  request fan-out and response return, error word for unmapped addresses
*/
`timescale 1ns/1ps

module cl_reg_demux (
  input  logic                         clk_i,
  input  logic                         reset_i,

  input  safety_cl_periph_pkg::reg_req_t in_req_i,
  output safety_cl_periph_pkg::reg_rsp_t in_rsp_o,

  output safety_cl_periph_pkg::reg_req_t [safety_cl_periph_pkg::NumPeriphs-1:0] out_req_o,
  input  safety_cl_periph_pkg::reg_rsp_t [safety_cl_periph_pkg::NumPeriphs-1:0] out_rsp_i
);

  logic                              hit;
  safety_cl_periph_pkg::periph_idx_e sel_d;
  safety_cl_periph_pkg::periph_idx_e sel_q;
  logic                              miss_q;

  always_comb begin
    logic [safety_cl_periph_pkg::AddrWidth-1:0] base;
    hit   = 1'b0;
    sel_d = safety_cl_periph_pkg::IdxIntc;
    for (int i = 0; i < safety_cl_periph_pkg::NumPeriphs; i++) begin
      base = safety_cl_periph_pkg::PeriphBaseAddr + safety_cl_periph_pkg::PeriphOffsets[i];
      if (in_req_i.addr >= base &&
          in_req_i.addr < base + safety_cl_periph_pkg::PeriphWindow) begin
        hit   = 1'b1;
        sel_d = safety_cl_periph_pkg::periph_idx_e'(i);
      end
    end
  end

  // Strobe only the selected slave
  always_comb begin
    for (int i = 0; i < safety_cl_periph_pkg::NumPeriphs; i++) begin
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = in_req_i.valid & hit & (sel_d == i[1:0]);
    end
  end

  // Remember where the next cycle's response comes from
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q  <= safety_cl_periph_pkg::IdxIntc;
      miss_q <= 1'b0;
    end else begin
      miss_q <= in_req_i.valid & ~hit;
      if (in_req_i.valid && hit) begin
        sel_q <= sel_d;
      end
    end
  end

  always_comb begin
    if (miss_q) begin
      in_rsp_o.valid = 1'b1;
      in_rsp_o.error = 1'b1;
      in_rsp_o.rdata = safety_cl_periph_pkg::ErrRespVal;
    end else begin
      in_rsp_o = out_rsp_i[sel_q];
    end
  end

endmodule

//--- err_fifo.sv
/*
  Small synchronous FIFO with a type-parameterized entry
  and a first-word-through head
*/
`timescale 1ns/1ps

module err_fifo #(
  parameter int unsigned Depth   = 2,
  parameter type         entry_t = logic
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   push_i,
  input  entry_t                 data_i,
  input  logic                   pop_i,
  output entry_t                 data_o,
  output logic                   empty_o,
  output logic                   full_o,
  output logic [$clog2(Depth):0] count_o
);

  localparam int unsigned PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CountWidth = $clog2(Depth) + 1;

  entry_t                mem [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CountWidth-1:0] count_q;
  logic                  push_en;
  logic                  pop_en;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CountWidth'(Depth));
  assign count_o = count_q;
  assign data_o  = mem[rd_ptr_q];

  // Push when full and pop when empty are dropped
  assign push_en = push_i & ~full_o;
  assign pop_en  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push_en != pop_en) begin
        count_q <= push_en ? count_q + 1'b1 : count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- safety_cl_periph_pkg.sv
/*
  Shared definitions of the core-local peripheral block: widths, address map,
  register offsets, slave enumeration and the packed bus structs
*/
package safety_cl_periph_pkg;

  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned NumBusErrBits = 2;

  // Interrupt sources: external, timer, then one per error unit
  localparam int unsigned NumExtIrqs   = 8;
  localparam int unsigned NumTimerIrqs = 2;
  localparam int unsigned NumIntrSrc   = 13;

  localparam int unsigned NumOutstanding  = 2;
  localparam int unsigned NumStoredErrors = 4;
  localparam int unsigned ErrCntWidth     = $clog2(NumStoredErrors) + 1;

  localparam logic [DataWidth-1:0] ErrRespVal = 32'hBADCAB1E;

  // Address map
  localparam logic [AddrWidth-1:0] PeriphBaseAddr  = 32'h0020_0000;
  localparam logic [AddrWidth-1:0] IntcOffset      = 32'h0000;
  localparam logic [AddrWidth-1:0] InstrErrOffset  = 32'h1000;
  localparam logic [AddrWidth-1:0] DataErrOffset   = 32'h1100;
  localparam logic [AddrWidth-1:0] ShadowErrOffset = 32'h1200;
  localparam logic [AddrWidth-1:0] PeriphWindow    = 32'h100;

  typedef enum logic [1:0] {
    IdxIntc,
    IdxInstrErr,
    IdxDataErr,
    IdxShadowErr
  } periph_idx_e;

  localparam int unsigned NumPeriphs = 4;

  // Window offsets in periph_idx_e order
  localparam logic [NumPeriphs-1:0][AddrWidth-1:0] PeriphOffsets = {
    ShadowErrOffset, DataErrOffset, InstrErrOffset, IntcOffset
  };

  // Register offsets inside a window
  localparam int unsigned RegOffsetWidth = $clog2(PeriphWindow);

  localparam logic [RegOffsetWidth-1:0] RegIntcEnable  = 8'h00;
  localparam logic [RegOffsetWidth-1:0] RegIntcPending = 8'h04;

  localparam logic [RegOffsetWidth-1:0] RegErrStatus = 8'h00;
  localparam logic [RegOffsetWidth-1:0] RegErrAddr   = 8'h04;
  localparam logic [RegOffsetWidth-1:0] RegErrCode   = 8'h08;
  localparam logic [RegOffsetWidth-1:0] RegErrPop    = 8'h0C;

  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 error;
    logic [DataWidth-1:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic                     req;
    logic                     gnt;
    logic                     rvalid;
    logic [AddrWidth-1:0]     addr;
    logic [NumBusErrBits-1:0] err;
  } obi_mon_t;

  typedef struct packed {
    logic [AddrWidth-1:0]     addr;
    logic [NumBusErrBits-1:0] err;
  } err_entry_t;

  typedef logic [3:0] irq_id_t;

endpackage
